// ==== project.f ====
rv_pkg.sv
inst_decoder.sv
reg_file.sv
alu_unit.sv
branch_unit.sv
retire_unit.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f project.f --top-module tb_rv_core -o sim_tb_rv_core

output="$(./obj_dir/sim_tb_rv_core 2>&1 || true)"
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== tb_rv_core.sv ====
/* testbench for the rv32i core
   plays instruction memory from a table of words and expected retire records */
`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam addr_t RESET_PC = 32'h8000_0000;
    localparam addr_t END_PC   = RESET_PC + 32'h0000_00c4;  // first pc past the program

    typedef struct packed {
        inst_word_t inst;
        retire_t    exp;
    } step_t;

    logic       clk;
    logic       reset;
    logic       inst_valid;
    inst_word_t inst;
    addr_t      pc;
    logic       retire_valid;
    retire_t    retire;

    step_t       prog [$];
    logic [31:0] rng_state;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #2 clk = ~clk;

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping after first failure");
    endtask

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: time %0d ns, %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction encoders
    function automatic inst_word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic inst_word_t i_type(logic [6:0] opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic inst_word_t u_type(logic [6:0] opc, int rd, int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic inst_word_t b_type(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_word_t j_type(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic void add_step(inst_word_t word, int pc_off, int next_off, int we,
                                     int rd, xlen_t data);
        step_t s;
        s.inst        = word;
        s.exp.pc      = RESET_PC + pc_off;
        s.exp.next_pc = RESET_PC + next_off;
        s.exp.we      = we[0];
        s.exp.rd      = rd[4:0];
        s.exp.data    = data;
        prog.push_back(s);
    endfunction

    function automatic void build_program();
        add_step(i_type(OPC_OP_IMM, 0, 1, 0, 5), 'h00, 'h04, 1, 1, 32'd5);       // addi x1
        add_step(i_type(OPC_OP_IMM, 0, 2, 0, -3), 'h04, 'h08, 1, 2, 32'hffff_fffd);
        add_step(u_type(OPC_LUI, 3, 'h12345), 'h08, 'h0c, 1, 3, 32'h1234_5000);
        add_step(u_type(OPC_AUIPC, 4, 1), 'h0c, 'h10, 1, 4, 32'h8000_100c);
        add_step(r_type(0, 0, 5, 1, 2), 'h10, 'h14, 1, 5, 32'd2);                // add
        add_step(r_type('h20, 0, 6, 1, 2), 'h14, 'h18, 1, 6, 32'd8);             // sub
        add_step(r_type(0, 1, 7, 1, 1), 'h18, 'h1c, 1, 7, 32'h0000_00a0);
        add_step(r_type('h20, 5, 8, 2, 1), 'h1c, 'h20, 1, 8, 32'hffff_ffff);     // sra of -3
        add_step(r_type(0, 5, 9, 2, 1), 'h20, 'h24, 1, 9, 32'h07ff_ffff);
        add_step(r_type(0, 2, 10, 2, 1), 'h24, 'h28, 1, 10, 32'd1);
        add_step(r_type(0, 3, 11, 2, 1), 'h28, 'h2c, 1, 11, 32'd0);
        add_step(r_type(0, 4, 12, 1, 3), 'h2c, 'h30, 1, 12, 32'h1234_5005);
        add_step(r_type(0, 6, 13, 1, 2), 'h30, 'h34, 1, 13, 32'hffff_fffd);
        add_step(r_type(0, 7, 14, 1, 2), 'h34, 'h38, 1, 14, 32'd5);
        // immediate forms
        add_step(i_type(OPC_OP_IMM, 1, 15, 1, 3), 'h38, 'h3c, 1, 15, 32'h0000_0028);
        add_step(i_type(OPC_OP_IMM, 5, 16, 2, 'h401), 'h3c, 'h40, 1, 16, 32'hffff_fffe);
        add_step(i_type(OPC_OP_IMM, 5, 17, 3, 12), 'h40, 'h44, 1, 17, 32'h0001_2345);
        add_step(i_type(OPC_OP_IMM, 2, 18, 2, -2), 'h44, 'h48, 1, 18, 32'd1);
        add_step(i_type(OPC_OP_IMM, 3, 19, 1, -1), 'h48, 'h4c, 1, 19, 32'd1);
        add_step(i_type(OPC_OP_IMM, 4, 20, 1, 'hf), 'h4c, 'h50, 1, 20, 32'h0000_000a);
        add_step(i_type(OPC_OP_IMM, 6, 21, 1, 'h10), 'h50, 'h54, 1, 21, 32'h0000_0015);
        add_step(i_type(OPC_OP_IMM, 7, 22, 2, 'hff), 'h54, 'h58, 1, 22, 32'h0000_00fd);
        add_step(i_type(OPC_OP_IMM, 0, 0, 1, 7), 'h58, 'h5c, 0, 0, 32'd0);       // to x0
        add_step(r_type(0, 0, 23, 0, 1), 'h5c, 'h60, 1, 23, 32'd5);
        // a branch offset of +8 puts 8 in the rd field
        add_step(b_type(0, 1, 1, 8), 'h60, 'h68, 0, 8, 32'd0);                   // beq taken
        add_step(b_type(0, 1, 2, 8), 'h68, 'h6c, 0, 8, 32'd0);
        add_step(b_type(1, 1, 2, 8), 'h6c, 'h74, 0, 8, 32'd0);                   // bne taken
        add_step(b_type(1, 1, 1, 8), 'h74, 'h78, 0, 8, 32'd0);
        add_step(b_type(4, 2, 1, 8), 'h78, 'h80, 0, 8, 32'd0);                   // blt taken
        add_step(b_type(4, 1, 2, 8), 'h80, 'h84, 0, 8, 32'd0);
        add_step(b_type(5, 1, 2, 8), 'h84, 'h8c, 0, 8, 32'd0);                   // bge taken
        add_step(b_type(5, 2, 1, 8), 'h8c, 'h90, 0, 8, 32'd0);
        add_step(b_type(6, 1, 2, 8), 'h90, 'h98, 0, 8, 32'd0);                   // bltu taken
        add_step(b_type(6, 2, 1, 8), 'h98, 'h9c, 0, 8, 32'd0);
        add_step(b_type(7, 2, 1, 8), 'h9c, 'ha4, 0, 8, 32'd0);                   // bgeu taken
        add_step(b_type(7, 1, 2, 8), 'ha4, 'ha8, 0, 8, 32'd0);
        // jal then jalr from an odd sum
        add_step(j_type(24, 12), 'ha8, 'hb4, 1, 24, 32'h8000_00ac);
        add_step(i_type(OPC_OP_IMM, 0, 25, 24, 'h11), 'hb4, 'hb8, 1, 25, 32'h8000_00bd);
        add_step(i_type(OPC_JALR, 0, 26, 25, 4), 'hb8, 'hc0, 1, 26, 32'h8000_00bc);
        add_step(r_type('h20, 0, 27, 26, 24), 'hc0, 'hc4, 1, 27, 32'h0000_0010);
    endfunction

    function automatic int find_step(addr_t at);
        for (int i = 0; i < prog.size(); i++) begin
            if (prog[i].exp.pc == at) return i;
        end
        return -1;
    endfunction

    // 0 to 3 idle cycles in which nothing may retire or move
    task automatic idle_gap();
        logic [1:0] gap;
        addr_t      held;
        rng_state = xorshift(rng_state);
        gap  = rng_state[2] ? rng_state[1:0] : 2'd0;
        held = pc;
        repeat (gap) begin
            @(negedge clk);
            check("retire_valid in idle gap", 32'(retire_valid), 32'd0);
            check("pc in idle gap", pc, held);
        end
    endtask

    task automatic run_step(step_t s);
        int cycles;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= s.inst;
        @(posedge clk);  // accepting edge
        inst_valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid) begin
            cycles++;
            if (cycles > 8) begin
                abort_run("timeout: retire_valid never rose after a strobe");
            end else begin
                @(negedge clk);
            end
        end
        check("retire.pc", retire.pc, s.exp.pc);
        check("retire.next_pc", retire.next_pc, s.exp.next_pc);
        check("retire.we", 32'(retire.we), 32'(s.exp.we));
        check("retire.rd", 32'(retire.rd), 32'(s.exp.rd));
        check("retire.data", retire.data, s.exp.data);
        check("pc after retire", pc, s.exp.next_pc);
    endtask

    initial begin
        int idx;
        int steps;
        clk        = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        rng_state  = 32'd12;
        build_program();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check("pc after reset", pc, RESET_PC);
            check("retire_valid before first strobe", 32'(retire_valid), 32'd0);
            check("retire.pc after reset", retire.pc, 32'd0);
        end
        steps = 0;
        while (pc != END_PC) begin
            idx = find_step(pc);
            steps++;
            if (idx < 0) begin
                abort_run($sformatf("core asked for pc %h, which the program never reaches",
                                    pc));
            end else if (steps > 100) begin
                abort_run("timeout: program did not reach its end address");
            end else begin
                idle_gap();
                run_step(prog[idx]);
            end
        end
        if (dut.u_asserts.fail_count != 0) begin
            abort_run("bound assertions on the core reported failures");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== rv_core_asserts.sv ====
/* core protocol assertions, bound into rv_core
   retire timing, pc hold while idle, no x0 writes retired */
`timescale 1ns/1ps

module rv_core_asserts
    import rv_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    inst_valid,
    input addr_t   pc,
    input logic    retire_valid,
    input retire_t retire
);

    int fail_count = 0;  // read by the testbench at the end

    // retire record one cycle after each accepting edge, never otherwise
    a_retire_follows: assert property (@(posedge clk) disable iff (reset)
        retire_valid == $past(inst_valid))
        else begin
            $error("retire_valid does not follow inst_valid by one cycle");
            fail_count++;
        end

    a_pc_holds: assert property (@(posedge clk) disable iff (reset)
        !inst_valid |=> $stable(pc))
        else begin
            $error("pc moved without an accepted instruction");
            fail_count++;
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        retire.we |-> retire.rd != 5'd0)
        else begin
            $error("retire record claims a write to x0");
            fail_count++;
        end

endmodule

bind rv_core rv_core_asserts u_asserts (.*);

// ==== rv_core.sv ====
/* rv32i integer core, one instruction per strobe
   decoder, register file, alu and branch units in parallel, retire unit */
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h8000_0000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       inst_valid,
    input  inst_word_t inst,
    output addr_t      pc,
    output logic       retire_valid,
    output retire_t    retire
);

    decoded_t dec;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    alu_result;
    logic     jump_en;
    addr_t    jump_target;
    logic     wr_en;
    reg_idx_t wr_idx;
    xlen_t    wr_data;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (dec.rs1),
        .rs2_idx  (dec.rs2),
        .wr_idx   (wr_idx),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu_unit u_alu (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result)
    );

    branch_unit u_branch (
        .dec         (dec),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    retire_unit #(
        .RESET_PC (RESET_PC)
    ) u_retire (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .dec          (dec),
        .alu_result   (alu_result),
        .jump_en      (jump_en),
        .jump_target  (jump_target),
        .pc           (pc),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// ==== retire_unit.sv ====
/* retire unit
   owns the pc, merges alu and branch results into the write and the retire record */
`timescale 1ns/1ps

module retire_unit
    import rv_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h8000_0000
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     inst_valid,
    input  decoded_t dec,
    input  xlen_t    alu_result,
    input  logic     jump_en,
    input  addr_t    jump_target,
    output addr_t    pc,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output xlen_t    wr_data,
    output logic     retire_valid,
    output retire_t  retire
);

    addr_t pc_plus4;
    addr_t next_pc;

    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = jump_en ? jump_target : pc_plus4;

    // link address for jal/jalr
    assign wr_data = (dec.wb_sel == WB_LINK) ? pc_plus4 : alu_result;
    assign wr_idx  = dec.rd;
    assign wr_en   = inst_valid && (dec.wb_sel != WB_NONE) && (dec.rd != 5'd0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (inst_valid) begin
            pc <= next_pc;
        end
    end

    // one cycle after each accepting edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire       <= '0;
        end else begin
            retire_valid <= inst_valid;
            if (inst_valid) begin
                retire.pc      <= pc;
                retire.next_pc <= next_pc;
                retire.we      <= wr_en;
                retire.rd      <= dec.rd;
                retire.data    <= wr_en ? wr_data : '0;
            end
        end
    end

endmodule

// ==== branch_unit.sv ====
/* branch unit
   evaluates the branch condition and computes the jump target */
`timescale 1ns/1ps

module branch_unit
    import rv_pkg::*;
(
    input  decoded_t dec,
    input  addr_t    pc,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output logic     jump_en,
    output addr_t    jump_target
);

    xlen_t jalr_sum;
    logic  cond;

    assign jalr_sum = rs1_data + dec.imm;

    // jalr clears bit 0, jal and branches are pc relative
    assign jump_target = dec.is_jalr ? {jalr_sum[31:1], 1'b0} : pc + dec.imm;

    always_comb begin
        case (dec.funct3)
            3'b000:  cond = (rs1_data == rs2_data);                    // beq
            3'b001:  cond = (rs1_data != rs2_data);                    // bne
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));   // blt
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));  // bge
            3'b110:  cond = (rs1_data < rs2_data);                     // bltu
            3'b111:  cond = (rs1_data >= rs2_data);                    // bgeu
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        if (dec.inst_type == TYPE_J || dec.is_jalr) begin
            jump_en = 1'b1;
        end else if (dec.inst_type == TYPE_B) begin
            jump_en = cond;
        end else begin
            jump_en = 1'b0;
        end
    end

endmodule

// ==== alu_unit.sv ====
/* execute unit
   selects the alu operands and computes the arithmetic or logic result */
`timescale 1ns/1ps

module alu_unit
    import rv_pkg::*;
(
    input  decoded_t dec,
    input  addr_t    pc,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output xlen_t    alu_result
);

    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;

    // operand a: zero for lui, pc for auipc, rs1 for the rest
    always_comb begin
        if (dec.is_lui) begin
            op_a = '0;
        end else if (dec.opcode == OPC_AUIPC) begin
            op_a = pc;
        end else begin
            op_a = rs1_data;
        end
    end

    assign op_b  = (dec.inst_type == TYPE_R) ? rs2_data : dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'd0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);  // keeps sign
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

endmodule

// ==== reg_file.sv ====
/* integer register file, 32 x 32 bits
   two combinational read ports, one write port, x0 reads as zero */
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t wr_idx,
    input  logic     wr_en,
    input  xlen_t    wr_data,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data
);

    xlen_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != 5'd0) begin  // x0 writes dropped
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 forced to zero on read as well
    always_comb begin
        rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
        rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];
    end

endmodule

// ==== inst_decoder.sv ====
/* instruction decoder
   splits a word into fields, class, immediate, alu operation and writeback source */
`timescale 1ns/1ps

module inst_decoder
    import rv_pkg::*;
(
    input  inst_word_t inst,
    output decoded_t   dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    inst_type_t inst_type;
    xlen_t      imm;
    alu_op_t    alu_op;
    wb_sel_t    wb_sel;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            OPC_OP:                        inst_type = TYPE_R;
            OPC_OP_IMM, OPC_JALR:          inst_type = TYPE_I;
            OPC_STORE:                     inst_type = TYPE_S;
            OPC_BRANCH:                    inst_type = TYPE_B;
            OPC_LUI, OPC_AUIPC:            inst_type = TYPE_U;
            OPC_JAL:                       inst_type = TYPE_J;
            default:                       inst_type = TYPE_N;
        endcase
    end

    // immediate layout follows the class
    always_comb begin
        case (inst_type)
            TYPE_I:  imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_S:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            TYPE_B:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            TYPE_U:  imm = {inst[31:12], 12'h000};
            TYPE_J:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;  // also covers lui, auipc, jalr
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    // only the register form has sub
                    if (inst_type == TYPE_R && funct7[5]) begin
                        alu_op = ALU_SUB;
                    end
                end
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // srai shares the bit
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OPC_JAL, OPC_JALR:                   wb_sel = WB_LINK;
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: wb_sel = WB_ALU;
            default:                             wb_sel = WB_NONE;
        endcase
    end

    always_comb begin
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm;
        dec.inst_type = inst_type;
        dec.alu_op    = alu_op;
        dec.wb_sel    = wb_sel;
        dec.is_jalr   = (opcode == OPC_JALR);
        dec.is_lui    = (opcode == OPC_LUI);
    end

endmodule

// ==== rv_pkg.sv ====
/* rv32i core shared definitions
   widths, decode enums, decoded and retire records, opcode values */
package rv_pkg;

    typedef logic [31:0] xlen_t;      // data word
    typedef logic [31:0] addr_t;      // instruction address
    typedef logic [31:0] inst_word_t;
    typedef logic [4:0]  reg_idx_t;

    // instruction class, by operand/immediate layout
    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // unknown or unsupported opcode
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // source of the register write
    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LINK  // pc + 4
    } wb_sel_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        xlen_t      imm;        // sign extended
        inst_type_t inst_type;
        alu_op_t    alu_op;
        wb_sel_t    wb_sel;
        logic       is_jalr;
        logic       is_lui;
    } decoded_t;

    typedef struct packed {
        addr_t    pc;
        addr_t    next_pc;
        logic     we;       // a register actually changed
        reg_idx_t rd;
        xlen_t    data;     // zero when we is low
    } retire_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;  // decoded as a no-op

endpackage
